// ==== common/pcie_inb_pkg.sv ====
`default_nettype none

package pcie_inb_pkg;

    typedef logic [31:0] dw_t;
    typedef logic [2:0]  tc_t;
    typedef logic [1:0]  attr_t;
    typedef logic [15:0] req_id_t;
    typedef logic [7:0]  tag_t;
    typedef logic [9:0]  len_t;
    typedef logic [11:0] byte_cnt_t;
    typedef logic [6:0]  low_addr_t;
    typedef logic [1:0]  resp_t;
    typedef logic [6:0]  fmt_type_t;
    typedef logic [2:0]  cpl_status_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // fmt and type fields in bits 30:24 of header DW0
    localparam fmt_type_t TLP_MRD32 = 7'b00_00000;
    localparam fmt_type_t TLP_MWR32 = 7'b10_00000;
    localparam fmt_type_t TLP_IOWR  = 7'b10_00010;
    localparam fmt_type_t TLP_CPL   = 7'b00_01010;
    localparam fmt_type_t TLP_CPLD  = 7'b10_01010;

    localparam cpl_status_t CPL_SC = 3'b000;
    localparam cpl_status_t CPL_UR = 3'b001;

    typedef struct packed {
        dw_t  data;
        logic last;
    } tlp_beat_t;

    // Requester context echoed into the completion
    typedef struct packed {
        logic    write;
        tc_t     tc;
        attr_t   attr;
        req_id_t req_id;
        tag_t    tag;
    } cpl_id_t;

    typedef struct packed {
        logic       write;
        logic       posted;
        logic [7:0] addr;
        len_t       len;
    } tgt_cmd_t;

    typedef struct packed {
        low_addr_t low_addr;
        len_t      len;
        byte_cnt_t byte_cnt;
        logic      last;
        resp_t     resp;
    } rd_hdr_t;

endpackage

`default_nettype wire

// ==== design/rvh_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvh_fifo #(
    parameter int DATA        = 32,
    parameter int DEPTH       = 16,
    parameter int ALMOST_FULL = 4
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             in_valid,
    output logic            in_ready,
    input  wire [DATA-1:0]  in_data,
    output logic            in_almost_full,
    output logic            out_valid,
    input  wire             out_ready,
    output logic [DATA-1:0] out_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [DATA-1:0] mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   mem_cnt;
    logic [CW-1:0]   count;
    logic            push;
    logic            load_out;
    logic            mem_rd;
    logic            mem_wr;

    // Occupancy counts the output stage too
    assign count          = mem_cnt + CW'(out_valid);
    assign in_ready       = (count < CW'(DEPTH));
    assign in_almost_full = (count >= CW'(DEPTH - ALMOST_FULL));
    assign push           = in_valid && in_ready;
    assign load_out       = !out_valid || out_ready;
    assign mem_rd         = load_out && (mem_cnt != '0);
    // Empty memory and free output stage means bypass
    assign mem_wr         = push && !(load_out && (mem_cnt == '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            mem_cnt <= mem_cnt + CW'(mem_wr) - CW'(mem_rd);
            if (load_out) begin
                out_valid <= mem_rd || push;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_data;
        end
        if (mem_rd) begin
            out_data <= mem[rd_ptr];
        end else if (load_out && push) begin
            out_data <= in_data;
        end
    end

    // Write pointer never laps the read pointer
    assert property (@(posedge clk) disable iff (rst) mem_cnt < CW'(DEPTH));

endmodule

`default_nettype wire

// ==== design/request_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module request_decoder (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rx_valid,
    output logic                         rx_ready,
    input  wire pcie_inb_pkg::tlp_beat_t rx_beat,
    output logic                         cpl_id_valid,
    input  wire                          cpl_id_ready,
    output pcie_inb_pkg::cpl_id_t        cpl_id,
    output logic                         cmd_valid,
    input  wire                          cmd_ready,
    output pcie_inb_pkg::tgt_cmd_t       cmd,
    output logic                         wdata_valid,
    input  wire                          wdata_ready,
    output pcie_inb_pkg::tlp_beat_t      wdata
);

    import pcie_inb_pkg::*;

    typedef enum logic [2:0] {HDR0, HDR1, HDR2, ISSUE, DATA, DROP} state_t;

    state_t     state;
    fmt_type_t  fmt_type;
    tc_t        tc_q;
    attr_t      attr_q;
    len_t       len_q;
    req_id_t    req_id_q;
    tag_t       tag_q;
    logic [7:0] addr_q;
    logic       rx_fire;
    logic       is_rd;
    logic       is_mwr;
    logic       is_iowr;
    logic       np;

    assign rx_fire = rx_valid && rx_ready;
    assign is_rd   = (fmt_type == TLP_MRD32);
    assign is_mwr  = (fmt_type == TLP_MWR32);
    assign is_iowr = (fmt_type == TLP_IOWR);
    assign np      = is_rd || is_iowr;

    always_comb begin
        case (state)
            HDR0, HDR1, HDR2, DROP: rx_ready = 1'b1;
            DATA:                   rx_ready = wdata_ready;
            default:                rx_ready = 1'b0;
        endcase
    end

    assign wdata_valid = (state == DATA) && rx_valid;
    assign wdata       = rx_beat;

    // cmd and cpl_id leave in the same cycle so both queues stay in order
    assign cmd_valid    = (state == ISSUE) && (!np || cpl_id_ready);
    assign cpl_id_valid = (state == ISSUE) && np && cmd_ready;
    assign cmd          = '{write: !is_rd, posted: is_mwr, addr: addr_q, len: len_q};
    assign cpl_id       = '{write: is_iowr, tc: tc_q, attr: attr_q,
                            req_id: req_id_q, tag: tag_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HDR0;
        end else begin
            case (state)
                HDR0: if (rx_fire) state <= HDR1;
                HDR1: if (rx_fire) state <= HDR2;
                HDR2: begin
                    if (rx_fire) begin
                        if (is_rd || is_mwr || is_iowr) begin
                            state <= ISSUE;
                        end else begin
                            state <= rx_beat.last ? HDR0 : DROP;
                        end
                    end
                end
                ISSUE: if (cmd_valid && cmd_ready) state <= is_rd ? HDR0 : DATA;
                DATA, DROP: if (rx_fire && rx_beat.last) state <= HDR0;
                default: state <= HDR0;
            endcase
        end
    end

    // Header fields
    always_ff @(posedge clk) begin
        if (rx_fire && state == HDR0) begin
            fmt_type <= rx_beat.data[30:24];
            tc_q     <= rx_beat.data[22:20];
            attr_q   <= rx_beat.data[13:12];
            len_q    <= rx_beat.data[9:0];
        end
        if (rx_fire && state == HDR1) begin
            req_id_q <= rx_beat.data[31:16];
            tag_q    <= rx_beat.data[15:8];
        end
        if (rx_fire && state == HDR2) begin
            addr_q <= rx_beat.data[9:2];
        end
    end

    // A request header is never a single beat
    assert property (@(posedge clk) disable iff (rst)
        (state == HDR0) && rx_fire |-> !rx_beat.last);

endmodule

`default_nettype wire

// ==== design/register_target.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_target #(
    parameter int REG_WORDS = 64
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cmd_valid,
    output logic                         cmd_ready,
    input  wire pcie_inb_pkg::tgt_cmd_t  cmd,
    input  wire                          wdata_valid,
    output logic                         wdata_ready,
    input  wire pcie_inb_pkg::tlp_beat_t wdata,
    output logic                         wr_resp_valid,
    input  wire                          wr_resp_ready,
    output pcie_inb_pkg::resp_t          wr_resp,
    output logic                         rd_hdr_valid,
    input  wire                          rd_hdr_ready,
    output pcie_inb_pkg::rd_hdr_t        rd_hdr,
    output logic                         rd_data_valid,
    input  wire                          rd_data_ready,
    output pcie_inb_pkg::tlp_beat_t      rd_data
);

    import pcie_inb_pkg::*;

    localparam int IW = (REG_WORDS > 1) ? $clog2(REG_WORDS) : 1;

    typedef enum logic [2:0] {IDLE, WRITE, WRESP, RHDR, RDATA} state_t;

    state_t      state;
    dw_t         regs [REG_WORDS];
    tgt_cmd_t    cmd_q;
    logic [7:0]  addr_cnt;
    logic [IW-1:0] idx;
    len_t        remain;
    logic        decerr;
    logic        range_err;
    logic [10:0] end_addr;

    assign end_addr  = {3'b000, cmd.addr} + {1'b0, cmd.len};
    assign range_err = (end_addr > 11'(REG_WORDS));
    assign idx       = IW'(addr_cnt);

    assign cmd_ready     = (state == IDLE);
    assign wdata_ready   = (state == WRITE);
    assign wr_resp_valid = (state == WRESP);
    assign wr_resp       = decerr ? RESP_DECERR : RESP_OKAY;
    assign rd_hdr_valid  = (state == RHDR);
    assign rd_hdr        = '{low_addr: {cmd_q.addr[4:0], 2'b00}, len: cmd_q.len,
                             byte_cnt: {cmd_q.len, 2'b00}, last: 1'b1,
                             resp: decerr ? RESP_DECERR : RESP_OKAY};
    assign rd_data_valid = (state == RDATA);
    // Zero words stand in for data under DECERR
    assign rd_data       = '{data: decerr ? '0 : regs[idx], last: (remain == len_t'(1))};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:  if (cmd_valid) state <= cmd.write ? WRITE : RHDR;
                WRITE: if (wdata_valid && wdata.last) state <= cmd_q.posted ? IDLE : WRESP;
                WRESP: if (wr_resp_ready) state <= IDLE;
                RHDR:  if (rd_hdr_ready) state <= RDATA;
                RDATA: if (rd_data_ready && rd_data.last) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q    <= cmd;
            addr_cnt <= cmd.addr;
            remain   <= cmd.len;
            decerr   <= range_err;
        end
        if (wdata_valid && wdata_ready) begin
            if (!decerr) begin
                regs[idx] <= wdata.data;
            end
            addr_cnt <= addr_cnt + 1'b1;
        end
        if (rd_data_valid && rd_data_ready) begin
            addr_cnt <= addr_cnt + 1'b1;
            remain   <= remain - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== completion/completion_builder.sv ====
`timescale 1ns/100ps
`default_nettype none

module completion_builder #(
    parameter int ID_DEPTH = 16,
    parameter int TX_DEPTH = 16
) (
    input  wire                          clk,
    input  wire                          rst,
    output logic                         rx_np_ok,
    input  wire                          cpl_id_valid,
    output logic                         cpl_id_ready,
    input  wire pcie_inb_pkg::cpl_id_t   cpl_id,
    input  wire                          wr_resp_valid,
    output logic                         wr_resp_ready,
    input  wire pcie_inb_pkg::resp_t     wr_resp,
    input  wire                          rd_hdr_valid,
    output logic                         rd_hdr_ready,
    input  wire pcie_inb_pkg::rd_hdr_t   rd_hdr,
    input  wire                          rd_data_valid,
    output logic                         rd_data_ready,
    input  wire pcie_inb_pkg::tlp_beat_t rd_data,
    output logic                         tx_valid,
    input  wire                          tx_ready,
    output pcie_inb_pkg::tlp_beat_t      tx_beat,
    input  wire [7:0]                    bus_number,
    input  wire [4:0]                    dev_number,
    input  wire [2:0]                    func_number
);

    import pcie_inb_pkg::*;

    // Free ID entries kept back before non-posted traffic is throttled
    localparam int NP_RESERVE = 4;

    typedef enum logic [2:0] {H0, H1, H2, DATA, FLUSH} state_t;

    state_t    st;
    state_t    st_nxt;
    logic      id_valid;
    logic      id_ready;
    logic      id_almost_full;
    cpl_id_t   id_q;
    logic      tlp_valid;
    logic      tlp_ready;
    logic      tlp_accept;
    tlp_beat_t tlp;
    logic      drop;
    logic      h_valid;
    logic      h_pop;
    logic      h_err;
    logic      h_last;
    low_addr_t h_addr;
    len_t      h_len;
    byte_cnt_t h_bytes;

    rvh_fifo #(
        .DATA        ($bits(cpl_id_t)),
        .DEPTH       (ID_DEPTH),
        .ALMOST_FULL (NP_RESERVE)
    ) u_id_fifo (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (cpl_id_valid),
        .in_ready       (cpl_id_ready),
        .in_data        (cpl_id),
        .in_almost_full (id_almost_full),
        .out_valid      (id_valid),
        .out_ready      (id_ready),
        .out_data       (id_q)
    );

    assign rx_np_ok = !id_almost_full;

    rvh_fifo #(
        .DATA        ($bits(tlp_beat_t)),
        .DEPTH       (TX_DEPTH),
        .ALMOST_FULL (1)
    ) u_tx_fifo (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (tlp_valid && !drop),
        .in_ready       (tlp_ready),
        .in_data        (tlp),
        .in_almost_full (),
        .out_valid      (tx_valid),
        .out_ready      (tx_ready),
        .out_data       (tx_beat)
    );

    // Header source follows the oldest buffered ID
    assign h_valid = id_valid && (id_q.write ? wr_resp_valid : rd_hdr_valid);

    always_comb begin
        h_addr  = '0;
        h_len   = len_t'(1);
        h_bytes = byte_cnt_t'(4);
        h_last  = 1'b1;
        h_err   = (wr_resp != RESP_OKAY);
        if (!id_q.write) begin
            h_addr  = rd_hdr.low_addr;
            h_len   = rd_hdr.len;
            h_bytes = rd_hdr.byte_cnt;
            h_last  = rd_hdr.last;
            h_err   = (rd_hdr.resp != RESP_OKAY);
        end
    end

    // While dropping, beats are consumed without reaching the TX FIFO
    assign tlp_accept    = tlp_valid && (tlp_ready || drop);
    assign h_pop         = (st == H2) && tlp_accept;
    assign wr_resp_ready = h_pop && id_q.write;
    assign rd_hdr_ready  = h_pop && !id_q.write;
    assign id_ready      = h_pop && h_last;

    always_comb begin
        st_nxt        = st;
        tlp_valid     = 1'b0;
        tlp           = '0;
        rd_data_ready = 1'b0;
        case (st)
            H0: begin
                tlp_valid       = h_valid;
                tlp.data[30:24] = (!id_q.write && !h_err) ? TLP_CPLD : TLP_CPL;
                tlp.data[22:20] = id_q.tc;
                tlp.data[13:12] = id_q.attr;
                tlp.data[9:0]   = h_len;
                st_nxt          = H1;
            end
            H1: begin
                tlp_valid       = h_valid;
                tlp.data[31:16] = {bus_number, dev_number, func_number};
                tlp.data[15:13] = h_err ? CPL_UR : CPL_SC;
                tlp.data[11:0]  = h_bytes;
                st_nxt          = H2;
            end
            H2: begin
                tlp_valid       = h_valid;
                tlp.data[31:16] = id_q.req_id;
                tlp.data[15:8]  = id_q.tag;
                tlp.data[6:0]   = h_addr;
                tlp.last        = id_q.write || h_err;
                st_nxt          = id_q.write ? H0 : (h_err ? FLUSH : DATA);
            end
            DATA: begin
                tlp_valid     = rd_data_valid;
                tlp           = rd_data;
                rd_data_ready = tlp_ready;
                st_nxt        = rd_data.last ? H0 : DATA;
            end
            FLUSH: begin
                tlp_valid     = rd_data_valid;
                tlp           = rd_data;
                rd_data_ready = 1'b1;
                st_nxt        = rd_data.last ? H0 : FLUSH;
            end
            default: st_nxt = H0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st   <= H0;
            drop <= 1'b0;
        end else begin
            if (tlp_accept) begin
                st <= st_nxt;
            end
            if (h_pop && h_err && !id_q.write) begin
                drop <= 1'b1;
            end else if (st == FLUSH && tlp_accept && rd_data.last) begin
                drop <= 1'b0;
            end
        end
    end

    // Read data only follows a completion header
    assert property (@(posedge clk) disable iff (rst)
        rd_data_valid |-> ((st == DATA) || (st == FLUSH)));

endmodule

`default_nettype wire

// ==== design/pcie_inbound_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_inbound_top #(
    parameter int REG_WORDS = 64,
    parameter int ID_DEPTH  = 16,
    parameter int TX_DEPTH  = 16
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rx_valid,
    output logic                         rx_ready,
    input  wire pcie_inb_pkg::tlp_beat_t rx_beat,
    output logic                         tx_valid,
    input  wire                          tx_ready,
    output pcie_inb_pkg::tlp_beat_t      tx_beat,
    output logic                         rx_np_ok,
    input  wire [7:0]                    bus_number,
    input  wire [4:0]                    dev_number,
    input  wire [2:0]                    func_number
);

    import pcie_inb_pkg::*;

    logic      cpl_id_valid;
    logic      cpl_id_ready;
    cpl_id_t   cpl_id;
    logic      cmd_valid;
    logic      cmd_ready;
    tgt_cmd_t  cmd;
    logic      wdata_valid;
    logic      wdata_ready;
    tlp_beat_t wdata;
    logic      wr_resp_valid;
    logic      wr_resp_ready;
    resp_t     wr_resp;
    logic      rd_hdr_valid;
    logic      rd_hdr_ready;
    rd_hdr_t   rd_hdr;
    logic      rd_data_valid;
    logic      rd_data_ready;
    tlp_beat_t rd_data;

    request_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_beat      (rx_beat),
        .cpl_id_valid (cpl_id_valid),
        .cpl_id_ready (cpl_id_ready),
        .cpl_id       (cpl_id),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd          (cmd),
        .wdata_valid  (wdata_valid),
        .wdata_ready  (wdata_ready),
        .wdata        (wdata)
    );

    register_target #(
        .REG_WORDS (REG_WORDS)
    ) u_target (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd           (cmd),
        .wdata_valid   (wdata_valid),
        .wdata_ready   (wdata_ready),
        .wdata         (wdata),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp_ready (wr_resp_ready),
        .wr_resp       (wr_resp),
        .rd_hdr_valid  (rd_hdr_valid),
        .rd_hdr_ready  (rd_hdr_ready),
        .rd_hdr        (rd_hdr),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .rd_data       (rd_data)
    );

    completion_builder #(
        .ID_DEPTH (ID_DEPTH),
        .TX_DEPTH (TX_DEPTH)
    ) u_builder (
        .clk           (clk),
        .rst           (rst),
        .rx_np_ok      (rx_np_ok),
        .cpl_id_valid  (cpl_id_valid),
        .cpl_id_ready  (cpl_id_ready),
        .cpl_id        (cpl_id),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp_ready (wr_resp_ready),
        .wr_resp       (wr_resp),
        .rd_hdr_valid  (rd_hdr_valid),
        .rd_hdr_ready  (rd_hdr_ready),
        .rd_hdr        (rd_hdr),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .rd_data       (rd_data),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .tx_beat       (tx_beat),
        .bus_number    (bus_number),
        .dev_number    (dev_number),
        .func_number   (func_number)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_pcie_inbound.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pcie_inbound;

    import pcie_inb_pkg::*;

    localparam int         REG_WORDS = 64;
    localparam int         NUM_TESTS = 7;
    localparam logic [7:0] BUS       = 8'h3a;
    localparam logic [4:0] DEV       = 5'h0c;
    localparam logic [2:0] FUNC      = 3'h5;
    localparam req_id_t    REQ_ID    = 16'h1a08;

    logic      clk;
    logic      rst;
    logic      rx_valid;
    logic      rx_ready;
    tlp_beat_t rx_beat;
    logic      tx_valid;
    logic      tx_ready;
    tlp_beat_t tx_beat;
    logic      rx_np_ok;

    dw_t       model [REG_WORDS];
    tlp_beat_t exp_q [$];
    dw_t       wr_data [$];
    integer    seed = 82160;
    int        errors = 0;
    int        faults = 0;
    int        checks = 0;
    int        beat_idx = 0;
    bit        sender_done;
    bit        throttled;

    pcie_inbound_top #(
        .REG_WORDS (REG_WORDS),
        .ID_DEPTH  (16),
        .TX_DEPTH  (16)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .rx_beat     (rx_beat),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_beat     (tx_beat),
        .rx_np_ok    (rx_np_ok),
        .bus_number  (BUS),
        .dev_number  (DEV),
        .func_number (FUNC)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Budget of 2000 cycles per test
    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("Watchdog expired before all tests completed");
        $display("Regression failed");
        $finish;
    end

    task automatic check_dw(input string name, input dw_t got, input dw_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_beat(input string name, input tlp_beat_t got, input tlp_beat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got data %h last %h expected data %h last %h",
                     name, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // DW0 layout shared by requests and completions
    function automatic dw_t dw0(input fmt_type_t ft, input tc_t tc, input attr_t attr,
                                input len_t len);
        return {1'b0, ft, 1'b0, tc, 6'b0, attr, 2'b0, len};
    endfunction

    function automatic dw_t byte_addr(input logic [7:0] waddr);
        return {22'b0, waddr, 2'b00};
    endfunction

    task automatic drive_beat(input dw_t data, input logic last);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_beat  = '{data: data, last: last};
        #1;
        while (!rx_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    // Header then whatever payload sits in wr_data
    task automatic send_request(input fmt_type_t ft, input logic [7:0] waddr, input len_t len,
                                input tag_t tag);
        int n;
        n = wr_data.size();
        drive_beat(dw0(ft, tag[2:0], tag[4:3], len), 1'b0);
        drive_beat({REQ_ID, tag, 8'h0f}, 1'b0);
        drive_beat(byte_addr(waddr), n == 0);
        for (int i = 0; i < n; i++) begin
            drive_beat(wr_data[i], i == n - 1);
        end
        wr_data.delete();
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic push_cpl_hdr(input fmt_type_t ft, input tag_t tag, input len_t len,
                                input cpl_status_t status, input byte_cnt_t bytes,
                                input low_addr_t low_addr, input logic last);
        exp_q.push_back('{data: dw0(ft, tag[2:0], tag[4:3], len), last: 1'b0});
        exp_q.push_back('{data: {BUS, DEV, FUNC, status, 1'b0, bytes}, last: 1'b0});
        exp_q.push_back('{data: {REQ_ID, tag, 1'b0, low_addr}, last: last});
    endtask

    task automatic mem_write(input logic [7:0] waddr, input len_t len, input tag_t tag);
        dw_t d;
        bit  ok;
        ok = int'(waddr) + int'(len) <= REG_WORDS;
        wr_data.delete();
        for (int i = 0; i < int'(len); i++) begin
            d = $random(seed);
            wr_data.push_back(d);
            if (ok) model[int'(waddr) + i] = d;
        end
        send_request(TLP_MWR32, waddr, len, tag);
    endtask

    task automatic io_write(input logic [7:0] waddr, input tag_t tag);
        dw_t d;
        bit  ok;
        d  = $random(seed);
        ok = int'(waddr) + 1 <= REG_WORDS;
        if (ok) model[waddr] = d;
        // Lower address is only meaningful for read completions
        push_cpl_hdr(TLP_CPL, tag, 10'd1, ok ? CPL_SC : CPL_UR, 12'd4, 7'h00, 1'b1);
        wr_data.delete();
        wr_data.push_back(d);
        send_request(TLP_IOWR, waddr, 10'd1, tag);
    endtask

    task automatic mem_read(input logic [7:0] waddr, input len_t len, input tag_t tag);
        bit  ok;
        dw_t a;
        ok = int'(waddr) + int'(len) <= REG_WORDS;
        a  = byte_addr(waddr);
        push_cpl_hdr(ok ? TLP_CPLD : TLP_CPL, tag, len, ok ? CPL_SC : CPL_UR,
                     byte_cnt_t'(int'(len) * 4), a[6:0], !ok);
        if (ok) begin
            for (int i = 0; i < int'(len); i++) begin
                exp_q.push_back('{data: model[int'(waddr) + i], last: i == int'(len) - 1});
            end
        end
        wr_data.delete();
        send_request(TLP_MRD32, waddr, len, tag);
    endtask

    task automatic take_beat(input bit rand_ready, output tlp_beat_t beat);
        bit got;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            tx_ready = rand_ready ? 1'($random(seed)) : 1'b1;
            #1;
            got = tx_valid && tx_ready;
        end
        beat = tx_beat;
        @(posedge clk);
    endtask

    task automatic check_next_beat(input bit rand_ready);
        tlp_beat_t got;
        tlp_beat_t exp;
        exp = exp_q.pop_front();
        take_beat(rand_ready, got);
        if (beat_idx < 3) begin
            check_dw($sformatf("tx_beat.data header dw%0d", beat_idx), got.data, exp.data);
            check_bit("tx_beat.last", got.last, exp.last);
        end else begin
            check_beat("tx_beat", got, exp);
        end
        beat_idx = exp.last ? 0 : beat_idx + 1;
    endtask

    task automatic park_tx();
        @(negedge clk);
        tx_ready = 1'b0;
    endtask

    task automatic collect_cpl(input bit rand_ready);
        bit done;
        done = 1'b0;
        while (!done) begin
            done = exp_q[0].last;
            check_next_beat(rand_ready);
        end
        park_tx();
    endtask

    // Runs alongside a sender until every queued completion is back
    task automatic drain_all(input bit rand_ready);
        while (!sender_done || exp_q.size() > 0) begin
            if (exp_q.size() > 0) begin
                check_next_beat(rand_ready);
            end else begin
                @(negedge clk);
                tx_ready = 1'b0;
            end
        end
        park_tx();
    endtask

    task automatic expect_tx_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            tx_ready = 1'b1;
            #1;
            if (tx_valid) begin
                faults++;
                $display("Unexpected completion beat %h on tx", tx_beat.data);
            end
        end
        park_tx();
    endtask

    task automatic fill_registers();
        for (int b = 0; b < REG_WORDS; b += 16) begin
            mem_write(8'(b), 10'd16, 8'h00);
        end
        expect_tx_quiet(40);
    endtask

    task automatic test_write_read();
        mem_write(8'h2c, 10'd4, 8'h11);
        expect_tx_quiet(30);
        mem_read(8'h2c, 10'd4, 8'h12);
        collect_cpl(1'b0);
        expect_tx_quiet(20);
    endtask

    task automatic test_io_write();
        io_write(8'h21, 8'h21);
        collect_cpl(1'b0);
        // 0x48 aliases word 8 in the bank, which must stay untouched
        io_write(8'h48, 8'h22);
        collect_cpl(1'b0);
        mem_read(8'h20, 10'd2, 8'h23);
        collect_cpl(1'b0);
        mem_read(8'h08, 10'd1, 8'h24);
        collect_cpl(1'b0);
        expect_tx_quiet(20);
    endtask

    task automatic test_bad_read();
        mem_read(8'h3c, 10'd8, 8'h31);
        mem_read(8'h10, 10'd5, 8'h32);
        collect_cpl(1'b0);
        collect_cpl(1'b0);
        expect_tx_quiet(20);
    endtask

    task automatic test_unsupported();
        // CfgWr0 with one data word, then a header-only MRdLk
        wr_data.delete();
        wr_data.push_back(32'hdead_0001);
        send_request(7'b10_00100, 8'h04, 10'd1, 8'h41);
        send_request(7'b00_00001, 8'h04, 10'd1, 8'h42);
        mem_read(8'h05, 10'd3, 8'h43);
        collect_cpl(1'b0);
        expect_tx_quiet(20);
    endtask

    task automatic test_random_reads();
        len_t       len;
        logic [7:0] addr;
        sender_done = 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    len  = len_t'(($random(seed) & 15) + 1);
                    addr = 8'({$random(seed)} % (REG_WORDS - int'(len) + 1));
                    mem_read(addr, len, 8'(8'h50 + i));
                end
                sender_done = 1'b1;
            end
            drain_all(1'b1);
        join
        expect_tx_quiet(20);
    endtask

    // Flow control shows as rx_np_ok low or as a stalled rx link
    task automatic test_np_throttle();
        int started;
        int stall;
        sender_done = 1'b0;
        throttled   = 1'b0;
        started     = 0;
        fork
            begin
                while (started < 16 && !throttled) begin
                    started++;
                    mem_read(8'(started * 3), 10'd2, 8'(8'h80 + started));
                end
                sender_done = 1'b1;
            end
            begin
                stall = 0;
                while (!throttled && !sender_done) begin
                    @(negedge clk);
                    #2;
                    if (!rx_np_ok) begin
                        throttled = 1'b1;
                        $display("rx_np_ok dropped with %0d reads issued", started);
                    end else begin
                        stall = (rx_valid && !rx_ready) ? stall + 1 : 0;
                        if (stall >= 32) begin
                            throttled = 1'b1;
                            $display("rx link stalled with %0d reads issued", started);
                        end
                    end
                end
                if (!throttled) begin
                    faults++;
                    $display("No flow control seen while tx_ready was held low");
                end
                if (started >= 16) begin
                    faults++;
                    $display("Flow control engaged only after 16 non-posted requests");
                end
                drain_all(1'b0);
            end
        join
        repeat (5) @(negedge clk);
        check_bit("rx_np_ok", rx_np_ok, 1'b1);
        expect_tx_quiet(20);
    endtask

    initial begin
        rst      = 1'b1;
        rx_valid = 1'b0;
        rx_beat  = '0;
        tx_ready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit("rx_np_ok", rx_np_ok, 1'b1);
        fill_registers();
        test_write_read();
        test_io_write();
        test_bad_read();
        test_unsupported();
        test_random_reads();
        test_np_throttle();
        $display("Checks: %0d, value mismatches: %0d, other failures: %0d",
                 checks, errors, faults);
        if (errors == 0 && faults == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pcie_inbound.f ====
common/pcie_inb_pkg.sv
design/rvh_fifo.sv
design/request_decoder.sv
design/register_target.sv
completion/completion_builder.sv
design/pcie_inbound_top.sv
testbench/tb_pcie_inbound.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_pcie_inbound -f pcie_inbound.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
